// ==== common/csrAddrPkg.sv ====
/*
  Machine-mode CSR map for RV32 only. Supervisor, user, debug and counter
  CSRs have no address here and read as illegal.
*/
`default_nettype none

package csrAddrPkg;

  // Data path width, RV32 only
  localparam int xlen = 32;
  // Interrupt pending/enable bits kept by the hart
  localparam int irqBits = 12;

  typedef logic [11:0] csrAddrT;

  //////////////////////////////
  // Machine CSR addresses
  //////////////////////////////
  localparam csrAddrT addrMvendorid     = 12'hF11;
  localparam csrAddrT addrMarchid       = 12'hF12;
  localparam csrAddrT addrMimpid        = 12'hF13;
  localparam csrAddrT addrMhartid       = 12'hF14;
  localparam csrAddrT addrMstatus       = 12'h300;
  localparam csrAddrT addrMisa          = 12'h301;
  localparam csrAddrT addrMedeleg       = 12'h302;
  localparam csrAddrT addrMideleg       = 12'h303;
  localparam csrAddrT addrMie           = 12'h304;
  localparam csrAddrT addrMtvec         = 12'h305;
  localparam csrAddrT addrMcounteren    = 12'h306;
  localparam csrAddrT addrMcountinhibit = 12'h320;
  localparam csrAddrT addrMscratch      = 12'h340;
  localparam csrAddrT addrMepc          = 12'h341;
  localparam csrAddrT addrMcause        = 12'h342;
  localparam csrAddrT addrMtval         = 12'h343;
  localparam csrAddrT addrMip           = 12'h344;
  // PMP config and address registers sit at consecutive addresses
  localparam csrAddrT addrPmpcfg0       = 12'h3A0;
  localparam csrAddrT addrPmpaddr0      = 12'h3B0;

  // PMP sizing, four 8-bit configs per pmpcfg word on RV32
  localparam int pmpEntries  = 16;
  localparam int pmpCfgRegs  = pmpEntries / 4;
  localparam int pmpIdxW     = $clog2(pmpEntries);
  localparam int pmpCfgIdxW  = $clog2(pmpCfgRegs);

  //////////////////////////////
  // Reset and hardwired values
  //////////////////////////////
  localparam logic [xlen-1:0] mcountinhibitReset = '1;
  localparam logic [xlen-1:0] mimpidValue        = 32'h0000_0100;
  // MXL=1 for RV32, extensions I (bit 8) and M (bit 12)
  localparam logic [xlen-1:0] misaValue          = 32'h4000_1100;

  // mstatus fields that exist in this hart
  localparam int mstatusMie   = 3;
  localparam int mstatusMpie  = 7;
  localparam int mstatusMppLo = 11;

  //////////////////////////////
  // Write masks
  //////////////////////////////
  // Exception 11, ecall from M-mode, cannot be delegated
  localparam logic [xlen-1:0] medelegMask = 32'hFFFF_F7FF;
  // Only the supervisor interrupt bits can be delegated
  localparam logic [xlen-1:0] midelegMask = 32'h0000_0222;
  // Modes 0 and 1 only, bit 1 stays low
  localparam logic [xlen-1:0] mtvecMask   = 32'hFFFF_FFFD;
  // MIE, MPIE and MPP
  localparam logic [xlen-1:0] mstatusMask = 32'h0000_1888;

endpackage

`default_nettype wire

// ==== common/csrOpPkg.sv ====
/*
  Stage-to-stage structs of the CSR pipe. Every struct carries its own
  valid bit and a stage with valid low does nothing.
*/
`default_nettype none

package csrOpPkg;

  import csrAddrPkg::*;

  // SYSTEM major opcode and the fixed MRET encoding
  localparam logic [6:0]  opcodeSystem = 7'b1110011;
  localparam logic [31:0] mretWord     = 32'h3020_0073;

  typedef enum logic [2:0] {
    opNone,
    opWrite,
    opSet,
    opClear,
    opMret
  } csrOpT;

  // Request from the pipeline, one per cycle
  typedef struct packed {
    logic            valid;
    logic [31:0]     instr;
    logic [xlen-1:0] rs1Val;
  } csrReqT;

  // Decoded operation, registered in decode
  typedef struct packed {
    logic            valid;
    csrOpT           op;
    csrAddrT         addr;
    logic [4:0]      rd;
    logic [xlen-1:0] src;
    logic            srcZero;
    logic            illegal;
  } csrDecT;

  // Write command from execute, also seen by result
  typedef struct packed {
    logic            valid;
    logic            we;
    csrAddrT         addr;
    logic [xlen-1:0] wdata;
    logic            mret;
    logic [4:0]      rd;
    logic            illegal;
  } csrWrT;

  // Writeback result for rd
  typedef struct packed {
    logic            valid;
    logic            rdWrite;
    logic [4:0]      rd;
    logic [xlen-1:0] rdValue;
    logic            illegal;
  } csrResT;

  // Trap entry request
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] epc;
    logic [xlen-1:0] cause;
    logic [xlen-1:0] tval;
  } trapReqT;

endpackage

`default_nettype wire

// ==== csr/csrDecode.sv ====
/*
  Only CSR instructions and MRET are decoded. ECALL, EBREAK and WFI come
  out as illegal and must be caught earlier in the pipeline.
*/
`timescale 1ns/100ps
`default_nettype none

module csrDecode import csrAddrPkg::*, csrOpPkg::*; (
  input  wire logic   clk,
  input  wire logic   rstN,
  input  wire logic   stall,
  input  wire csrReqT req,
  output csrDecT      dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] rs1Field;
  logic       isSystem;
  logic       isMret;
  csrDecT     decNext;

  // Instruction fields
  assign opcode   = req.instr[6:0];
  assign funct3   = req.instr[14:12];
  assign rs1Field = req.instr[19:15];
  assign isSystem = (opcode == opcodeSystem);
  assign isMret   = (req.instr == mretWord);

  always_comb begin
    decNext.valid = req.valid;
    decNext.addr  = req.instr[31:20];
    decNext.rd    = req.instr[11:7];
    // funct3[2] picks the zero-extended uimm over rs1
    if (funct3[2]) begin
      decNext.src = {{(xlen-5){1'b0}}, rs1Field};
    end else begin
      decNext.src = req.rs1Val;
    end
    // Same field for both forms
    decNext.srcZero = (rs1Field == 5'd0);

    // Reserved funct3 and non-MRET privileged words
    decNext.illegal = !isSystem || (funct3 == 3'b100) || ((funct3 == 3'b000) && !isMret);

    case (funct3[1:0])
      2'b01:   decNext.op = opWrite;
      2'b10:   decNext.op = opSet;
      2'b11:   decNext.op = opClear;
      default: decNext.op = isMret ? opMret : opNone;
    endcase
    // Illegal words carry no operation
    if (decNext.illegal) begin
      decNext.op = opNone;
    end
  end

  //////////////////////////////
  // Decode register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      dec <= '0;
    end else if (!stall) begin
      dec <= decNext;
    end
  end

endmodule

`default_nettype wire

// ==== csr/csrExecute.sv ====
/*
  Purely combinational. Read and write of a CSR occur in this one stage,
  so back-to-back operations need no forwarding.
*/
`timescale 1ns/100ps
`default_nettype none

module csrExecute import csrAddrPkg::*, csrOpPkg::*; (
  input  wire csrDecT          dec,
  input  wire logic [xlen-1:0] readVal,
  input  wire logic            readIllegal,
  output csrAddrT              readAddr,
  output csrWrT                wr
);

  logic            isCsr;
  logic            wantWrite;
  logic            roTarget;
  logic            illegal;
  logic [xlen-1:0] newVal;

  // Read port follows the decoded address
  assign readAddr = dec.addr;

  assign isCsr = dec.op inside {opWrite, opSet, opClear};

  // CSRRS and CSRRC with a zero source only read
  assign wantWrite = dec.valid && ((dec.op == opWrite) ||
                                   (((dec.op == opSet) || (dec.op == opClear)) && !dec.srcZero));

  // ID registers and misa are read-only
  assign roTarget = dec.addr inside {addrMvendorid, addrMarchid, addrMimpid, addrMhartid,
                                     addrMisa};

  // Decode faults, unmapped CSRs and writes to read-only CSRs
  assign illegal = dec.valid && (dec.illegal || (isCsr && readIllegal) ||
                                 (wantWrite && roTarget));

  // New value from the old one
  always_comb begin
    case (dec.op)
      opWrite: newVal = dec.src;
      opSet:   newVal = readVal | dec.src;
      opClear: newVal = readVal & ~dec.src;
      default: newVal = readVal;
    endcase
  end

  always_comb begin
    wr.valid   = dec.valid;
    wr.we      = wantWrite && !illegal;
    wr.addr    = dec.addr;
    wr.wdata   = newVal;
    wr.mret    = dec.valid && (dec.op == opMret) && !illegal;
    wr.rd      = dec.rd;
    wr.illegal = illegal;
  end

  // Decode hands over illegal words with no operation
  always_comb begin
    assert final (!(dec.valid && dec.illegal && (dec.op != opNone)))
      else $error("Illegal decoded word carries a CSR operation");
  end

endmodule

`default_nettype wire

// ==== csr/csrMachine.sv ====
/*
  M-mode register file. PMP entries are storage only, no locking or
  checking. A trap wins over MRET and over a CSR write in the same cycle.
*/
`timescale 1ns/100ps
`default_nettype none

module csrMachine import csrAddrPkg::*, csrOpPkg::*; (
  input  wire logic               clk,
  input  wire logic               rstN,
  input  wire logic               stall,
  input  wire csrAddrT            readAddr,
  output logic [xlen-1:0]         readVal,
  output logic                    readIllegal,
  input  wire csrWrT              wr,
  input  wire trapReqT            trap,
  input  wire logic [irqBits-1:0] mip,
  output logic [xlen-1:0]         trapVector,
  output logic [xlen-1:0]         retAddr
);

  logic [xlen-1:0]    mstatus;
  logic [xlen-1:0]    mtvec;
  logic [xlen-1:0]    medeleg;
  logic [xlen-1:0]    mideleg;
  logic [irqBits-1:0] mie;
  logic [xlen-1:0]    mscratch;
  logic [xlen-1:0]    mepc;
  logic [xlen-1:0]    mcause;
  logic [xlen-1:0]    mtval;
  logic [xlen-1:0]    mcounteren;
  logic [xlen-1:0]    mcountinhibit;
  logic [pmpCfgRegs-1:0][xlen-1:0] pmpCfg;
  logic [pmpEntries-1:0][xlen-1:0] pmpAddr;

  // Offsets into the PMP blocks, wrap makes low addresses miss
  csrAddrT rdPmpAddrOff;
  csrAddrT rdPmpCfgOff;
  csrAddrT wrPmpAddrOff;
  csrAddrT wrPmpCfgOff;
  logic    rdPmpAddrHit;
  logic    rdPmpCfgHit;
  logic    wrPmpAddrHit;
  logic    wrPmpCfgHit;

  assign rdPmpAddrOff = readAddr - addrPmpaddr0;
  assign rdPmpCfgOff  = readAddr - addrPmpcfg0;
  assign wrPmpAddrOff = wr.addr - addrPmpaddr0;
  assign wrPmpCfgOff  = wr.addr - addrPmpcfg0;
  assign rdPmpAddrHit = (rdPmpAddrOff < csrAddrT'(pmpEntries));
  assign rdPmpCfgHit  = (rdPmpCfgOff < csrAddrT'(pmpCfgRegs));
  assign wrPmpAddrHit = (wrPmpAddrOff < csrAddrT'(pmpEntries));
  assign wrPmpCfgHit  = (wrPmpCfgOff < csrAddrT'(pmpCfgRegs));

  //////////////////////////////
  // Register updates
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mstatus       <= '0;
      mtvec         <= '0;
      medeleg       <= '0;
      mideleg       <= '0;
      mie           <= '0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= '0;
      mcountinhibit <= mcountinhibitReset;
      pmpCfg        <= '0;
      pmpAddr       <= '0;
    end else if (!stall) begin
      if (trap.valid) begin
        // Trap entry from M-mode
        mepc                       <= trap.epc;
        mcause                     <= trap.cause;
        mtval                      <= trap.tval;
        mstatus[mstatusMpie]       <= mstatus[mstatusMie];
        mstatus[mstatusMie]        <= 1'b0;
        mstatus[mstatusMppLo +: 2] <= 2'b11;
      end else if (wr.mret) begin
        // Restore interrupt enable
        mstatus[mstatusMie]        <= mstatus[mstatusMpie];
        mstatus[mstatusMpie]       <= 1'b1;
        mstatus[mstatusMppLo +: 2] <= 2'b00;
      end else if (wr.we) begin
        case (wr.addr)
          addrMstatus:       mstatus       <= wr.wdata & mstatusMask;
          addrMtvec:         mtvec         <= wr.wdata & mtvecMask;
          addrMedeleg:       medeleg       <= wr.wdata & medelegMask;
          addrMideleg:       mideleg       <= wr.wdata & midelegMask;
          addrMie:           mie           <= wr.wdata[irqBits-1:0];
          addrMscratch:      mscratch      <= wr.wdata;
          addrMepc:          mepc          <= wr.wdata;
          addrMcause:        mcause        <= wr.wdata;
          addrMtval:         mtval         <= wr.wdata;
          addrMcounteren:    mcounteren    <= wr.wdata;
          addrMcountinhibit: mcountinhibit <= wr.wdata;
          default: begin
            // PMP blocks by offset, mip writes fall through
            if (wrPmpAddrHit) begin
              pmpAddr[wrPmpAddrOff[pmpIdxW-1:0]] <= wr.wdata;
            end
            if (wrPmpCfgHit) begin
              pmpCfg[wrPmpCfgOff[pmpCfgIdxW-1:0]] <= wr.wdata;
            end
          end
        endcase
      end
    end
  end

  //////////////////////////////
  // Read mux
  //////////////////////////////
  always_comb begin
    readVal     = '0;
    readIllegal = 1'b0;
    if (rdPmpAddrHit) begin
      readVal = pmpAddr[rdPmpAddrOff[pmpIdxW-1:0]];
    end else if (rdPmpCfgHit) begin
      readVal = pmpCfg[rdPmpCfgOff[pmpCfgIdxW-1:0]];
    end else begin
      case (readAddr)
        addrMisa:          readVal = misaValue;
        addrMvendorid:     readVal = '0;
        addrMarchid:       readVal = '0;
        addrMimpid:        readVal = mimpidValue;
        addrMhartid:       readVal = '0;
        addrMstatus:       readVal = mstatus;
        addrMtvec:         readVal = mtvec;
        addrMedeleg:       readVal = medeleg;
        addrMideleg:       readVal = mideleg;
        addrMie:           readVal = {{(xlen-irqBits){1'b0}}, mie};
        addrMip:           readVal = {{(xlen-irqBits){1'b0}}, mip};
        addrMscratch:      readVal = mscratch;
        addrMepc:          readVal = mepc;
        addrMcause:        readVal = mcause;
        addrMtval:         readVal = mtval;
        addrMcounteren:    readVal = mcounteren;
        addrMcountinhibit: readVal = mcountinhibit;
        // Anything else is outside this hart
        default:           readIllegal = 1'b1;
      endcase
    end
  end

  // To fetch
  assign trapVector = mtvec;
  assign retAddr    = mepc;

  // A stalled cycle leaves every CSR as it was
  assert property (@(posedge clk) rstN && stall |=>
    $stable({mstatus, mtvec, medeleg, mideleg, mie, mscratch, mepc, mcause, mtval,
             mcounteren, mcountinhibit, pmpCfg, pmpAddr}))
    else $error("CSR changed during stall");

endmodule

`default_nettype wire

// ==== csr/csrResult.sv ====
/*
  Result register for rd. Illegal operations keep valid high so that the
  pipeline can raise the exception, but never write rd.
*/
`timescale 1ns/100ps
`default_nettype none

module csrResult import csrAddrPkg::*, csrOpPkg::*; (
  input  wire logic            clk,
  input  wire logic            rstN,
  input  wire logic            stall,
  input  wire csrWrT           wr,
  input  wire logic [xlen-1:0] readVal,
  output csrResT               res
);

  csrResT resNext;

  always_comb begin
    resNext.valid   = wr.valid;
    // CSR ops only, MRET and x0 write nothing
    resNext.rdWrite = wr.valid && !wr.illegal && !wr.mret && (wr.rd != 5'd0);
    resNext.rd      = wr.rd;
    // rd always gets the value before the write
    resNext.rdValue = readVal;
    resNext.illegal = wr.valid && wr.illegal;
  end

  //////////////////////////////
  // Result register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      res <= '0;
    end else if (!stall) begin
      res <= resNext;
    end
  end

  // An illegal operation taken by execute never writes rd one cycle later
  assert property (@(posedge clk) disable iff (!rstN)
    wr.valid && wr.illegal && !stall |=> res.illegal && !res.rdWrite)
    else $error("rd write on an illegal CSR operation");

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+test
common/csrAddrPkg.sv
common/csrOpPkg.sv
csr/csrDecode.sv
csr/csrExecute.sv
csr/csrMachine.sv
csr/csrResult.sv
src/csrUnit.sv
test/csrUnitTb.sv

// ==== src/csrUnit.sv ====
/*
  Two cycles from an accepted request to res.valid. Stall freezes all
  stages and all CSRs, trap entries included.
*/
`timescale 1ns/100ps
`default_nettype none

module csrUnit import csrAddrPkg::*, csrOpPkg::*; (
  input  wire logic               clk,
  input  wire logic               rstN,
  input  wire logic               stall,
  input  wire csrReqT             req,
  input  wire trapReqT            trap,
  input  wire logic [irqBits-1:0] mip,
  output csrResT                  res,
  output logic [xlen-1:0]         trapVector,
  output logic [xlen-1:0]         retAddr
);

  csrDecT          dec;
  csrWrT           wr;
  csrAddrT         readAddr;
  logic [xlen-1:0] readVal;
  logic            readIllegal;

  // Stage 1 registers the decoded op
  csrDecode decodeStage (
    .clk   (clk),
    .rstN  (rstN),
    .stall (stall),
    .req   (req),
    .dec   (dec)
  );

  // Stage 2 reads and writes the CSR
  csrExecute executeStage (
    .dec         (dec),
    .readVal     (readVal),
    .readIllegal (readIllegal),
    .readAddr    (readAddr),
    .wr          (wr)
  );

  csrMachine machineRegs (
    .clk         (clk),
    .rstN        (rstN),
    .stall       (stall),
    .readAddr    (readAddr),
    .readVal     (readVal),
    .readIllegal (readIllegal),
    .wr          (wr),
    .trap        (trap),
    .mip         (mip),
    .trapVector  (trapVector),
    .retAddr     (retAddr)
  );

  // Result registered at the same edge as the write
  csrResult resultStage (
    .clk     (clk),
    .rstN    (rstN),
    .stall   (stall),
    .wr      (wr),
    .readVal (readVal),
    .res     (res)
  );

endmodule

`default_nettype wire

// ==== test/csrUnitTasks.svh ====
/*
  Drive, compare and reference helpers for the CSR unit testbench.
  Needs clk, req, res, rngState and the error counters declared first.
*/
`ifndef CSR_UNIT_TASKS_SVH
`define CSR_UNIT_TASKS_SVH

//////////////////////////////
// Stimulus helpers
//////////////////////////////
// 32-bit xorshift, one step per call
function automatic logic [31:0] nextRand();
  rngState = rngState ^ (rngState << 13);
  rngState = rngState ^ (rngState >> 17);
  rngState = rngState ^ (rngState << 5);
  nextRand = rngState;
endfunction

// I-type SYSTEM word, opcode 1110011
function automatic logic [31:0] csrInstr(input logic [2:0] f3, input csrAddrT addr,
                                         input logic [4:0] rs1, input logic [4:0] rd);
  csrInstr = {addr, rs1, f3, rd, 7'b1110011};
endfunction

// PMP index 0 to 15 are pmpaddr, 16 to 19 are pmpcfg
function automatic csrAddrT pmpAddrOf(input int idx);
  if (idx < pmpEntries) begin
    pmpAddrOf = csrAddrT'(addrPmpaddr0 + idx);
  end else begin
    pmpAddrOf = csrAddrT'(addrPmpcfg0 + idx - pmpEntries);
  end
endfunction

// New CSR value by the Zicsr rules
function automatic logic [xlen-1:0] rmwExpect(input logic [2:0] f3,
                                              input logic [xlen-1:0] old,
                                              input logic [4:0] rs1,
                                              input logic [xlen-1:0] rs1Val);
  logic [xlen-1:0] src;
  // Immediate forms take the rs1 field as uimm
  src = f3[2] ? {{(xlen-5){1'b0}}, rs1} : rs1Val;
  case (f3[1:0])
    2'b01:   rmwExpect = src;
    2'b10:   rmwExpect = old | src;
    2'b11:   rmwExpect = old & ~src;
    default: rmwExpect = old;
  endcase
endfunction

// One request, result sampled after the second edge
task automatic issueReq(input logic [31:0] instr, input logic [xlen-1:0] rs1Val,
                        output csrResT got);
  req.valid  = 1'b1;
  req.instr  = instr;
  req.rs1Val = rs1Val;
  @(posedge clk);
  #driveDelay;
  req = '0;
  @(posedge clk);
  #driveDelay;
  got = res;
endtask

//////////////////////////////
// Compare tasks
//////////////////////////////
// valid and rdWrite always count
// The rest only for a valid item and rdValue only when rd is written
task automatic compareRes(input csrResT got, input csrResT exp, input string what);
  logic bad;
  bad = (got.valid !== exp.valid) || (got.rdWrite !== exp.rdWrite);
  if (exp.valid) begin
    bad = bad || (got.illegal !== exp.illegal);
    bad = bad || (got.rd !== exp.rd);
    if (exp.rdWrite) begin
      bad = bad || (got.rdValue !== exp.rdValue);
    end
  end
  if (bad) begin
    resErrors++;
    $display("ERR @%0t: %s got v=%b w=%b rd=%0d val=%h ill=%b", $time, what,
             got.valid, got.rdWrite, got.rd, got.rdValue, got.illegal);
    $display("ERR @%0t: %s expected v=%b w=%b rd=%0d val=%h ill=%b", $time, what,
             exp.valid, exp.rdWrite, exp.rd, exp.rdValue, exp.illegal);
  end
endtask

task automatic compareWord(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                           input string what);
  if (got !== exp) begin
    wordErrors++;
    $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
  end
endtask

//////////////////////////////
// Operation plus check
//////////////////////////////
task automatic runCsr(input logic [2:0] f3, input csrAddrT addr, input logic [4:0] rs1,
                      input logic [xlen-1:0] rs1Val, input logic [4:0] rd,
                      input logic [xlen-1:0] oldVal, input logic illegal,
                      input string what);
  csrResT got;
  csrResT exp;
  issueReq(csrInstr(f3, addr, rs1, rd), rs1Val, got);
  exp.valid   = 1'b1;
  exp.rdWrite = !illegal && (rd != 5'd0);
  exp.rd      = rd;
  exp.rdValue = oldVal;
  exp.illegal = illegal;
  compareRes(got, exp, what);
endtask

// CSRRS with x0 reads without writing
task automatic readCheck(input csrAddrT addr, input logic [xlen-1:0] expVal);
  runCsr(3'b010, addr, 5'd0, '0, 5'd5, expVal, 1'b0, $sformatf("read of CSR %h", addr));
endtask

`endif

// ==== test/csrUnitTb.sv ====
/*
  Directed tests of the CSR unit. Each request waits the fixed two-cycle
  latency. mip is held constant for the whole run.
*/
`timescale 1ns/100ps
`default_nettype none

module csrUnitTb import csrAddrPkg::*, csrOpPkg::*; ();

  localparam int clkPeriod     = 40;
  localparam int driveDelay    = 2;
  localparam int resetCycles   = 10;
  localparam int stallCycles   = 5;
  localparam int testCount     = 6;
  localparam int cyclesPerTest = 40;
  localparam int cycleLimit    = testCount * cyclesPerTest + resetCycles;
  // Machine timer interrupt pending
  localparam logic [irqBits-1:0] mipDrive = 12'h080;

  logic               clk;
  logic               rstN;
  logic               stall;
  csrReqT             req;
  trapReqT            trap;
  logic [irqBits-1:0] mip;
  csrResT             res;
  logic [xlen-1:0]    trapVector;
  logic [xlen-1:0]    retAddr;

  logic [31:0]     rngState = 32'h3b6c;
  int              resErrors = 0;
  int              wordErrors = 0;
  int              cycleCount = 0;
  // Expected mscratch across tests
  logic [xlen-1:0] scratchModel = '0;
  logic [xlen-1:0] pmpVals [pmpEntries + pmpCfgRegs];

  `include "csrUnitTasks.svh"

  csrUnit UUT (
    .clk        (clk),
    .rstN       (rstN),
    .stall      (stall),
    .req        (req),
    .trap       (trap),
    .mip        (mip),
    .res        (res),
    .trapVector (trapVector),
    .retAddr    (retAddr)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic checkResetValues();
    compareRes(res, csrResT'('0), "res after reset");
    readCheck(addrMvendorid, '0);
    readCheck(addrMarchid, '0);
    readCheck(addrMimpid, 32'h0000_0100);
    readCheck(addrMhartid, '0);
    readCheck(addrMisa, misaValue);
    readCheck(addrMstatus, '0);
    readCheck(addrMtvec, '0);
    readCheck(addrMedeleg, '0);
    readCheck(addrMideleg, '0);
    readCheck(addrMie, '0);
    readCheck(addrMip, {{(xlen-irqBits){1'b0}}, mipDrive});
    readCheck(addrMscratch, '0);
    readCheck(addrMepc, '0);
    readCheck(addrMcause, '0);
    readCheck(addrMtval, '0);
    readCheck(addrMcounteren, '0);
    readCheck(addrMcountinhibit, 32'hFFFF_FFFF);
    readCheck(addrPmpcfg0, '0);
    readCheck(addrPmpaddr0, '0);
    // rs1 field x0 means no write even with a nonzero operand
    runCsr(3'b011, addrMcountinhibit, 5'd0, '1, 5'd4, 32'hFFFF_FFFF, 1'b0, "csrrc x0");
    readCheck(addrMcountinhibit, 32'hFFFF_FFFF);
  endtask

  task automatic runScratchRmw();
    logic [2:0]      f3;
    logic [4:0]      rs1;
    logic [4:0]      rd;
    logic [xlen-1:0] rs1Val;
    logic [xlen-1:0] newVal;
    for (int i = 0; i < 6; i++) begin
      // Register forms 1 to 3, immediate forms 5 to 7
      f3     = (i < 3) ? 3'(i + 1) : 3'(i + 2);
      rs1    = 5'(nextRand()) | 5'd1;
      rd     = 5'(nextRand()) | 5'd1;
      rs1Val = nextRand();
      newVal = rmwExpect(f3, scratchModel, rs1, rs1Val);
      runCsr(f3, addrMscratch, rs1, rs1Val, rd, scratchModel, 1'b0,
             $sformatf("mscratch funct3 %0d", f3));
      scratchModel = newVal;
    end
    readCheck(addrMscratch, scratchModel);
  endtask

  task automatic probeWriteMasks();
    runCsr(3'b001, addrMtvec, 5'd1, '1, 5'd2, '0, 1'b0, "mtvec write");
    runCsr(3'b001, addrMedeleg, 5'd1, '1, 5'd2, '0, 1'b0, "medeleg write");
    runCsr(3'b001, addrMideleg, 5'd1, '1, 5'd2, '0, 1'b0, "mideleg write");
    runCsr(3'b001, addrMstatus, 5'd1, '1, 5'd2, '0, 1'b0, "mstatus write");
    readCheck(addrMtvec, 32'hFFFF_FFFF & mtvecMask);
    readCheck(addrMedeleg, 32'hFFFF_FFFF & medelegMask);
    readCheck(addrMideleg, 32'hFFFF_FFFF & midelegMask);
    readCheck(addrMstatus, 32'hFFFF_FFFF & mstatusMask);
    compareWord(trapVector, 32'hFFFF_FFFF & mtvecMask, "trapVector");
  endtask

  task automatic rejectIllegalOps();
    // 0x7C0 is a custom CSR this hart lacks
    runCsr(3'b010, 12'h7C0, 5'd0, '0, 5'd7, '0, 1'b1, "unknown CSR");
    runCsr(3'b001, addrMvendorid, 5'd3, nextRand(), 5'd7, '0, 1'b1, "mvendorid write");
    readCheck(addrMvendorid, '0);
    // funct3 100 is reserved
    runCsr(3'b100, addrMscratch, 5'd9, nextRand(), 5'd7, '0, 1'b1, "funct3 100");
    readCheck(addrMscratch, scratchModel);
  endtask

  task automatic enterTrapAndReturn();
    logic [xlen-1:0] epc;
    logic [xlen-1:0] cause;
    logic [xlen-1:0] tval;
    csrResT          got;
    epc   = nextRand() & ~32'h3;
    cause = nextRand();
    tval  = nextRand();
    // Clean mstatus, then MIE alone
    runCsr(3'b001, addrMstatus, 5'd1, '0, 5'd3, mstatusMask, 1'b0, "mstatus clear");
    runCsr(3'b110, addrMstatus, 5'd8, '0, 5'd3, '0, 1'b0, "csrrsi MIE");
    trap.valid = 1'b1;
    trap.epc   = epc;
    trap.cause = cause;
    trap.tval  = tval;
    @(posedge clk);
    #driveDelay;
    trap = '0;
    compareWord(retAddr, epc, "retAddr");
    readCheck(addrMepc, epc);
    readCheck(addrMcause, cause);
    readCheck(addrMtval, tval);
    // MPIE takes the old MIE and MIE drops
    issueReq(csrInstr(3'b010, addrMstatus, 5'd0, 5'd0), '0, got);
    compareWord(got.rdValue & 32'h88, 32'h80, "mstatus MPIE/MIE after trap");
    // MRET has a fixed encoding and writes no rd
    issueReq(32'h3020_0073, '0, got);
    compareRes(got, csrResT'({1'b1, 1'b0, 5'd0, {xlen{1'b0}}, 1'b0}), "mret");
    issueReq(csrInstr(3'b010, addrMstatus, 5'd0, 5'd0), '0, got);
    compareWord(got.rdValue & 32'h88, 32'h88, "mstatus MPIE/MIE after mret");
  endtask

  task automatic pmpAndStall();
    logic [xlen-1:0] newVal;
    int              startCycle;
    for (int i = 0; i < pmpEntries + pmpCfgRegs; i++) begin
      pmpVals[i] = nextRand();
      runCsr(3'b001, pmpAddrOf(i), 5'd7, pmpVals[i], 5'd8, '0, 1'b0, "pmp write");
    end
    for (int i = 0; i < pmpEntries + pmpCfgRegs; i++) begin
      readCheck(pmpAddrOf(i), pmpVals[i]);
    end
    // Write to mscratch frozen right after acceptance
    newVal     = nextRand();
    startCycle = cycleCount;
    req        = {1'b1, csrInstr(3'b001, addrMscratch, 5'd4, 5'd6), newVal};
    @(posedge clk);
    #driveDelay;
    req   = '0;
    stall = 1'b1;
    repeat (stallCycles) begin
      @(posedge clk);
      #driveDelay;
      compareRes(res, csrResT'('0), "res during stall");
    end
    stall = 1'b0;
    @(posedge clk);
    #driveDelay;
    // Old value proves the CSR held through the stall
    compareRes(res, csrResT'({1'b1, 1'b1, 5'd6, scratchModel, 1'b0}), "stalled write");
    compareWord(cycleCount - startCycle, 2 + stallCycles, "stalled latency");
    scratchModel = newVal;
    readCheck(addrMscratch, scratchModel);
  endtask

  //////////////////////////////
  // Sequence and watchdog
  //////////////////////////////
  initial begin
    rstN  = 1'b0;
    stall = 1'b0;
    req   = '0;
    trap  = '0;
    mip   = mipDrive;
    repeat (resetCycles) @(posedge clk);
    #driveDelay;
    rstN = 1'b1;
    checkResetValues();
    runScratchRmw();
    probeWriteMasks();
    rejectIllegalOps();
    enterTrapAndReturn();
    pmpAndStall();
    $display("Errors: %0d result mismatches, %0d value mismatches", resErrors, wordErrors);
    if (resErrors + wordErrors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: test sequence still running after %0d cycles", cycleCount);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire
